//--- core_types_pkg.sv
package core_types_pkg;

    typedef logic [31:0] word_t;    // Data and instruction word
    typedef logic [4:0]  reg_idx_t; // Register number, x0 to x31

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B                  // Operand b straight through, used by LUI
    } alu_op_t;

    // Source of an execute operand
    typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_t;

    // Source of the value written back to rd
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_t;

endpackage

//--- rv_isa_pkg.sv
package rv_isa_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Major opcodes, insn[6:0]
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [6:0] OPC_OP     = 7'b011_0011; // Register-register ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b001_0011; // Register-immediate ALU
    localparam logic [6:0] OPC_LUI    = 7'b011_0111;
    localparam logic [6:0] OPC_LOAD   = 7'b000_0011;
    localparam logic [6:0] OPC_STORE  = 7'b010_0011;
    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
    localparam logic [6:0] OPC_JAL    = 7'b110_1111;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // funct3, insn[14:12]
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [2:0] F3_ADD = 3'b000;          // ADD, SUB and ADDI
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // funct7 and fixed encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Bit 5 of funct7 sits at insn[30] and turns ADD into SUB
    localparam int F7_SUB_BIT = 30;

    // ADDI x0, x0, 0
    localparam logic [31:0] INSN_NOP = 32'h0000_0013;

endpackage

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                     CLK,
    input  logic                     RESET_N,
    input  core_types_pkg::reg_idx_t rs1,
    input  core_types_pkg::reg_idx_t rs2,
    input  core_types_pkg::reg_idx_t rd,
    input  core_types_pkg::word_t    wdata,
    input  logic                     we,
    output core_types_pkg::word_t    rdata1,
    output core_types_pkg::word_t    rdata2
);

    core_types_pkg::word_t regs [1:31]; // x0 has no storage

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // A write in the same cycle shows on the read port at once
    assign rdata1 = (rs1 == '0)       ? '0    :
                    (we && rd == rs1) ? wdata : regs[rs1];
    assign rdata2 = (rs2 == '0)       ? '0    :
                    (we && rd == rs2) ? wdata : regs[rs2];

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu (
    input  core_types_pkg::word_t   a,
    input  core_types_pkg::word_t   b,
    input  core_types_pkg::alu_op_t op,
    output core_types_pkg::word_t   result,
    output logic                    zero
);

    logic less_signed;

    assign less_signed = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            core_types_pkg::ALU_ADD:    result = a + b;
            core_types_pkg::ALU_SUB:    result = a - b;
            core_types_pkg::ALU_AND:    result = a & b;
            core_types_pkg::ALU_OR:     result = a | b;
            core_types_pkg::ALU_XOR:    result = a ^ b;
            core_types_pkg::ALU_SLT:    result = {31'd0, less_signed};
            core_types_pkg::ALU_PASS_B: result = b;
            default:                    result = '0;
        endcase
    end

    // After a SUB this is the equality test for BEQ and BNE
    assign zero = (result == '0);

endmodule

//--- decode_control.sv
`timescale 1ns/1ps

module decode_control (
    input  core_types_pkg::word_t   insn,
    output logic                    reg_write,
    output logic                    mem_read,
    output logic                    mem_write,
    output logic                    alu_src_imm,
    output logic                    branch,
    output logic                    jump,
    output core_types_pkg::wb_sel_t wb_sel,
    output core_types_pkg::alu_op_t alu_op,
    output core_types_pkg::word_t   imm
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic                  writes_rd;
    core_types_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opcode = insn[6:0];
    assign funct3 = insn[14:12];

    assign imm_i = {{20{insn[31]}}, insn[31:20]};
    assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
    assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    assign imm_u = {insn[31:12], 12'd0};
    assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

    assign reg_write = writes_rd && (insn[11:7] != 5'd0); // NOP and JAL x0 write nothing

    function automatic core_types_pkg::alu_op_t f3_op(logic [2:0] f3, logic sub);
        case (f3)
            rv_isa_pkg::F3_ADD: return sub ? core_types_pkg::ALU_SUB : core_types_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLT: return core_types_pkg::ALU_SLT;
            rv_isa_pkg::F3_XOR: return core_types_pkg::ALU_XOR;
            rv_isa_pkg::F3_OR:  return core_types_pkg::ALU_OR;
            rv_isa_pkg::F3_AND: return core_types_pkg::ALU_AND;
            default:            return core_types_pkg::ALU_ADD;
        endcase
    endfunction

    always_comb begin
        writes_rd   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        alu_src_imm = 1'b0;
        branch      = 1'b0;
        jump        = 1'b0;
        wb_sel      = core_types_pkg::WB_ALU;
        alu_op      = core_types_pkg::ALU_ADD;
        imm         = '0;
        case (opcode)
            rv_isa_pkg::OPC_OP: begin
                writes_rd = 1'b1;
                alu_op    = f3_op(funct3, insn[rv_isa_pkg::F7_SUB_BIT]);
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                writes_rd   = 1'b1;
                alu_src_imm = 1'b1;
                alu_op      = f3_op(funct3, 1'b0); // There is no SUBI
                imm         = imm_i;
            end
            rv_isa_pkg::OPC_LUI: begin
                writes_rd   = 1'b1;
                alu_src_imm = 1'b1;
                alu_op      = core_types_pkg::ALU_PASS_B;
                imm         = imm_u;
            end
            rv_isa_pkg::OPC_LOAD: begin
                writes_rd   = 1'b1;
                mem_read    = 1'b1;
                alu_src_imm = 1'b1;
                wb_sel      = core_types_pkg::WB_MEM;
                imm         = imm_i;
            end
            rv_isa_pkg::OPC_STORE: begin
                mem_write   = 1'b1;
                alu_src_imm = 1'b1;
                imm         = imm_s;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                branch = 1'b1;
                alu_op = core_types_pkg::ALU_SUB; // Compared through the zero flag
                imm    = imm_b;
            end
            rv_isa_pkg::OPC_JAL: begin
                writes_rd = 1'b1;
                jump      = 1'b1;
                wb_sel    = core_types_pkg::WB_PC4;
                imm       = imm_j;
            end
            default: begin
            end
        endcase
    end

endmodule

//--- hazard_forward.sv
`timescale 1ns/1ps

module hazard_forward (
    input  core_types_pkg::reg_idx_t id_rs1,
    input  core_types_pkg::reg_idx_t id_rs2,
    input  core_types_pkg::reg_idx_t ex_rd,
    input  core_types_pkg::reg_idx_t ex_rs1,
    input  core_types_pkg::reg_idx_t ex_rs2,
    input  core_types_pkg::reg_idx_t mem_rd,
    input  core_types_pkg::reg_idx_t wb_rd,
    input  logic                     ex_mem_read,
    input  logic                     mem_reg_write,
    input  logic                     wb_reg_write,
    output logic                     stall,
    output core_types_pkg::fwd_sel_t fwd_a,
    output core_types_pkg::fwd_sel_t fwd_b
);

    // Load data only exists after the memory stage, so its user waits one cycle
    assign stall = ex_mem_read && (ex_rd != '0) &&
                   (ex_rd == id_rs1 || ex_rd == id_rs2);

    // The younger producer in the memory stage wins over writeback
    function automatic core_types_pkg::fwd_sel_t pick(
        core_types_pkg::reg_idx_t src,
        logic                     m_we,
        core_types_pkg::reg_idx_t m_rd,
        logic                     w_we,
        core_types_pkg::reg_idx_t w_rd
    );
        if (src == '0) begin
            return core_types_pkg::FWD_REG;
        end else if (m_we && m_rd == src) begin
            return core_types_pkg::FWD_MEM;
        end else if (w_we && w_rd == src) begin
            return core_types_pkg::FWD_WB;
        end
        return core_types_pkg::FWD_REG;
    endfunction

    assign fwd_a = pick(ex_rs1, mem_reg_write, mem_rd, wb_reg_write, wb_rd);
    assign fwd_b = pick(ex_rs2, mem_reg_write, mem_rd, wb_reg_write, wb_rd);

endmodule

//--- pipelined_core.sv
`timescale 1ns/1ps

module pipelined_core #(
    parameter int ADDR_SIZE = 8
) (
    input  logic                     CLK,
    input  logic                     RESET_N,
    input  logic                     CLEAR,
    input  core_types_pkg::word_t    idata,
    output logic [ADDR_SIZE-1:0]     iaddr,
    output logic [ADDR_SIZE-1:0]     daddr,
    input  core_types_pkg::word_t    ddata_r,
    output core_types_pkg::word_t    ddata_w,
    output logic                     mem_read,
    output logic                     mem_write,
    output core_types_pkg::word_t    reg_write_data,
    output logic                     reg_write_enable,
    output core_types_pkg::reg_idx_t write_register
);

    localparam int PC_W = ADDR_SIZE + 2; // Byte address of a word

    logic [PC_W-1:0] pc, id_pc, ex_pc, br_target;
    logic take_branch, stall, id_kill, alu_zero;
    logic id_reg_write, id_mem_read, id_mem_write, id_alu_src_imm, id_branch, id_jump;
    logic ex_reg_write, ex_mem_read, ex_mem_write, ex_alu_src_imm, ex_branch, ex_jump, ex_br_ne;
    logic mem_reg_write, wb_reg_write;
    core_types_pkg::word_t id_insn, id_imm, id_rdata1, id_rdata2;
    core_types_pkg::word_t ex_imm, ex_rdata1, ex_rdata2, ex_link;
    core_types_pkg::word_t opnd_a, opnd_b, rs2_fwd, alu_result;
    core_types_pkg::word_t mem_alu, mem_wdata, mem_link;
    core_types_pkg::word_t wb_alu, wb_load, wb_link, wb_value;
    core_types_pkg::reg_idx_t ex_rs1, ex_rs2, ex_rd, mem_rd, wb_rd;
    core_types_pkg::wb_sel_t  id_wb_sel, ex_wb_sel, mem_wb_sel, wb_value_sel;
    core_types_pkg::alu_op_t  id_alu_op, ex_alu_op;
    core_types_pkg::fwd_sel_t fwd_a, fwd_b;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~ Fetch
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= '0;
        end else if (!CLEAR) begin
            if (take_branch) begin
                pc <= br_target;
            end else if (!stall) begin
                pc <= pc + PC_W'(4);
            end
        end
    end

    assign iaddr = pc[PC_W-1:2];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~ IF/ID
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            id_insn <= rv_isa_pkg::INSN_NOP;
        end else if (CLEAR || take_branch) begin
            id_insn <= rv_isa_pkg::INSN_NOP; // Drop the wrong-path fetch
        end else if (!stall) begin
            id_insn <= idata;
        end
    end

    always_ff @(posedge CLK) begin
        if (!stall) begin
            id_pc <= pc;
        end
    end

    decode_control u_decode (
        .insn(id_insn), .reg_write(id_reg_write), .mem_read(id_mem_read),
        .mem_write(id_mem_write), .alu_src_imm(id_alu_src_imm), .branch(id_branch),
        .jump(id_jump), .wb_sel(id_wb_sel), .alu_op(id_alu_op), .imm(id_imm)
    );

    reg_file u_regs (
        .CLK(CLK), .RESET_N(RESET_N), .rs1(id_insn[19:15]), .rs2(id_insn[24:20]),
        .rd(wb_rd), .wdata(wb_value), .we(wb_reg_write),
        .rdata1(id_rdata1), .rdata2(id_rdata2)
    );

    hazard_forward u_hazard (
        .id_rs1(id_insn[19:15]), .id_rs2(id_insn[24:20]), .ex_rd(ex_rd),
        .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .mem_rd(mem_rd), .wb_rd(wb_rd),
        .ex_mem_read(ex_mem_read), .mem_reg_write(mem_reg_write),
        .wb_reg_write(wb_reg_write), .stall(stall), .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~ ID/EX
    assign id_kill = CLEAR || take_branch || stall; // Bubble into execute

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            {ex_reg_write, ex_mem_read, ex_mem_write, ex_branch, ex_jump} <= '0;
        end else begin
            ex_reg_write <= id_reg_write && !id_kill;
            ex_mem_read  <= id_mem_read && !id_kill;
            ex_mem_write <= id_mem_write && !id_kill;
            ex_branch    <= id_branch && !id_kill;
            ex_jump      <= id_jump && !id_kill;
        end
    end

    always_ff @(posedge CLK) begin
        ex_pc          <= id_pc;
        ex_rdata1      <= id_rdata1;
        ex_rdata2      <= id_rdata2;
        ex_imm         <= id_imm;
        ex_rs1         <= id_insn[19:15];
        ex_rs2         <= id_insn[24:20];
        ex_rd          <= id_insn[11:7];
        ex_alu_src_imm <= id_alu_src_imm;
        ex_alu_op      <= id_alu_op;
        ex_wb_sel      <= id_wb_sel;
        ex_br_ne       <= (id_insn[14:12] == rv_isa_pkg::F3_BNE);
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~ Execute
    assign opnd_a  = (fwd_a == core_types_pkg::FWD_MEM) ? mem_alu  :
                     (fwd_a == core_types_pkg::FWD_WB)  ? wb_value : ex_rdata1;
    assign rs2_fwd = (fwd_b == core_types_pkg::FWD_MEM) ? mem_alu  :
                     (fwd_b == core_types_pkg::FWD_WB)  ? wb_value : ex_rdata2;
    assign opnd_b  = ex_alu_src_imm ? ex_imm : rs2_fwd;

    alu u_alu (.a(opnd_a), .b(opnd_b), .op(ex_alu_op), .result(alu_result), .zero(alu_zero));

    // Static not-taken prediction, so a taken branch costs the two younger slots
    assign take_branch = ex_jump || (ex_branch && (alu_zero ^ ex_br_ne));
    assign br_target   = ex_pc + ex_imm[PC_W-1:0];
    assign ex_link     = core_types_pkg::word_t'(ex_pc) + 32'd4;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~ EX/MEM
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            {mem_reg_write, mem_read, mem_write} <= '0;
        end else begin
            mem_reg_write <= ex_reg_write && !CLEAR;
            mem_read      <= ex_mem_read && !CLEAR;
            mem_write     <= ex_mem_write && !CLEAR;
        end
    end

    always_ff @(posedge CLK) begin
        mem_alu    <= alu_result;
        mem_wdata  <= rs2_fwd;
        mem_link   <= ex_link;
        mem_rd     <= ex_rd;
        mem_wb_sel <= ex_wb_sel;
    end

    assign daddr   = mem_alu[PC_W-1:2];
    assign ddata_w = mem_wdata;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~ MEM/WB
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            wb_reg_write <= 1'b0;
        end else begin
            wb_reg_write <= mem_reg_write && !CLEAR;
        end
    end

    always_ff @(posedge CLK) begin
        wb_alu       <= mem_alu;
        wb_load      <= ddata_r;
        wb_link      <= mem_link;
        wb_rd        <= mem_rd;
        wb_value_sel <= mem_wb_sel;
    end

    assign wb_value = (wb_value_sel == core_types_pkg::WB_MEM) ? wb_load :
                      (wb_value_sel == core_types_pkg::WB_PC4) ? wb_link : wb_alu;

    assign reg_write_data   = wb_value;
    assign reg_write_enable = wb_reg_write;
    assign write_register   = wb_rd;

    mem_strobes_exclusive: assert property (@(posedge CLK) disable iff (!RESET_N)
        !(mem_read && mem_write));

    // The bubble clears the load from execute, so a stall never repeats
    stall_single_cycle: assert property (@(posedge CLK) disable iff (!RESET_N)
        stall |=> !stall);

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic CLK,
    output logic RESET_N
);

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK; // 40 ns period
    end

    initial begin
        RESET_N = 1'b0;
        repeat (10) @(posedge CLK);
        @(negedge CLK) RESET_N = 1'b1; // Released on a falling edge
    end

endmodule

//--- tb_pipelined_core.sv
`timescale 1ns/1ps

module tb_pipelined_core;

    localparam int PROG_LEN = 22;
    localparam int N_EXP = 14;
    localparam int WATCH_CYCLES = 4 * PROG_LEN + 40;

    logic CLK, RESET_N, CLEAR;
    logic [7:0] iaddr, daddr;
    logic mem_read, mem_write, reg_write_enable;
    core_types_pkg::word_t idata, ddata_r, ddata_w, reg_write_data, want_val, store_val;
    core_types_pkg::reg_idx_t write_register, want_rd;
    core_types_pkg::word_t imem [0:255];
    core_types_pkg::word_t dmem [0:255];
    core_types_pkg::word_t exp_val [0:15];
    core_types_pkg::reg_idx_t exp_rd [0:15];
    logic [3:0] exp_pos;
    logic [11:0] imm_a, imm_b;
    int exp_idx = 0, check_fails = 0, pass_count = 0, fail_count = 0, store_count = 0;

    tb_clock_gen u_clk (.CLK(CLK), .RESET_N(RESET_N));

    pipelined_core #(.ADDR_SIZE(8)) UUT (
        .CLK(CLK), .RESET_N(RESET_N), .CLEAR(CLEAR), .idata(idata), .iaddr(iaddr),
        .daddr(daddr), .ddata_r(ddata_r), .ddata_w(ddata_w), .mem_read(mem_read),
        .mem_write(mem_write), .reg_write_data(reg_write_data),
        .reg_write_enable(reg_write_enable), .write_register(write_register)
    );

    assign idata    = imem[iaddr];
    assign ddata_r  = dmem[daddr];
    assign exp_pos  = (exp_idx < N_EXP) ? exp_idx[3:0] : 4'(N_EXP); // Loop link repeats last
    assign want_rd  = exp_rd[exp_pos];
    assign want_val = exp_val[exp_pos];

    always @(posedge CLK) begin
        if (mem_write) dmem[daddr] <= ddata_w;
        if (mem_write) store_count <= store_count + 1;
        if (RESET_N && reg_write_enable) exp_idx <= exp_idx + 1;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~ Instruction encoders
    function automatic core_types_pkg::word_t i_type(logic [11:0] imm, logic [4:0] rs1,
                                                     logic [2:0] f3, logic [4:0] rd,
                                                     logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic core_types_pkg::word_t r_type(logic [6:0] f7, logic [4:0] rs2,
                                                     logic [4:0] rs1, logic [2:0] f3,
                                                     logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
    endfunction

    function automatic core_types_pkg::word_t b_type(logic [12:0] imm, logic [4:0] rs2,
                                                     logic [4:0] rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::OPC_BRANCH};
    endfunction

    function automatic core_types_pkg::word_t j_type(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::OPC_JAL};
    endfunction

    task automatic finish_test(input string name, input int fails_before);
        if (check_fails == fails_before) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: FAILED with %0d errors", name, check_fails - fails_before);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~ Checks
    reset_quiet: assert property (@(posedge CLK) (!RESET_N || $rose(RESET_N)) |->
        (!mem_read && !mem_write && !reg_write_enable && iaddr == '0))
        else begin
            check_fails++;
            $display("core not idle with iaddr 0 around reset");
        end

    retire_rd: assert property (@(posedge CLK) disable iff (!RESET_N)
        reg_write_enable |-> write_register == want_rd)
        else begin
            check_fails++;
            $display("MISMATCH write_register got %h expected %h",
                     $sampled(write_register), $sampled(want_rd));
        end

    retire_value: assert property (@(posedge CLK) disable iff (!RESET_N)
        reg_write_enable |-> reg_write_data == want_val)
        else begin
            check_fails++;
            $display("MISMATCH reg_write_data got %h expected %h",
                     $sampled(reg_write_data), $sampled(want_val));
        end

    no_shadow_write: assert property (@(posedge CLK) disable iff (!RESET_N)
        reg_write_enable |-> !(write_register inside {5'd13, 5'd14, 5'd16}))
        else begin
            check_fails++;
            $display("a skipped instruction wrote its register");
        end

    store_addr: assert property (@(posedge CLK) disable iff (!RESET_N)
        mem_write |-> daddr == 8'd4)
        else begin
            check_fails++;
            $display("MISMATCH daddr got %h expected 04", $sampled(daddr));
        end

    store_data: assert property (@(posedge CLK) disable iff (!RESET_N)
        mem_write |-> ddata_w == store_val)
        else begin
            check_fails++;
            $display("MISMATCH ddata_w got %h expected %h",
                     $sampled(ddata_w), $sampled(store_val));
        end

    // Strobes are registered, so CLEAR shows on them one edge after it is sampled
    clear_quiet: assert property (@(posedge CLK) disable iff (!RESET_N)
        CLEAR |=> (!reg_write_enable && !mem_write))
        else begin
            check_fails++;
            $display("write strobe seen while CLEAR was high");
        end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~ Program and expected writes
    initial begin
        core_types_pkg::word_t a, b;
        int f0;
        void'($urandom(32'h842a_d635));
        imm_a = 12'($urandom);
        imm_b = 12'($urandom);
        CLEAR = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = rv_isa_pkg::INSN_NOP;
            dmem[i] = 32'hd00d_0000 | 32'(i * 3);
        end
        imem[0]  = i_type(imm_a, 0, rv_isa_pkg::F3_ADD, 1, rv_isa_pkg::OPC_OP_IMM);
        imem[1]  = i_type(imm_b, 0, rv_isa_pkg::F3_ADD, 2, rv_isa_pkg::OPC_OP_IMM);
        imem[2]  = r_type(7'h00, 2, 1, rv_isa_pkg::F3_ADD, 3);
        imem[3]  = r_type(7'h20, 1, 3, rv_isa_pkg::F3_ADD, 6); // SUB
        imem[4]  = r_type(7'h00, 3, 6, rv_isa_pkg::F3_AND, 7);
        imem[5]  = r_type(7'h00, 1, 7, rv_isa_pkg::F3_OR, 8);
        imem[6]  = r_type(7'h00, 2, 8, rv_isa_pkg::F3_XOR, 9);
        imem[7]  = r_type(7'h00, 2, 1, rv_isa_pkg::F3_SLT, 10);
        imem[8]  = {20'h12345, 5'd11, rv_isa_pkg::OPC_LUI};
        imem[9]  = {7'd0, 5'd3, 5'd0, 3'b010, 5'd16, rv_isa_pkg::OPC_STORE}; // SW x3, 16(x0)
        imem[10] = i_type(12'd16, 0, 3'b010, 4, rv_isa_pkg::OPC_LOAD);
        imem[11] = r_type(7'h00, 4, 4, rv_isa_pkg::F3_ADD, 5);
        imem[12] = b_type(13'd8, 0, 11, rv_isa_pkg::F3_BEQ);   // Not taken
        imem[13] = i_type(12'd5, 0, rv_isa_pkg::F3_ADD, 12, rv_isa_pkg::OPC_OP_IMM);
        imem[14] = b_type(13'd12, 0, 11, rv_isa_pkg::F3_BNE);  // Taken, to 17
        imem[15] = i_type(12'd1, 0, rv_isa_pkg::F3_ADD, 13, rv_isa_pkg::OPC_OP_IMM);
        imem[16] = i_type(12'd2, 0, rv_isa_pkg::F3_ADD, 14, rv_isa_pkg::OPC_OP_IMM);
        imem[17] = j_type(21'd8, 15);
        imem[18] = i_type(12'd3, 0, rv_isa_pkg::F3_ADD, 16, rv_isa_pkg::OPC_OP_IMM);
        imem[19] = i_type(12'd7, 0, rv_isa_pkg::F3_ADD, 0, rv_isa_pkg::OPC_OP_IMM);
        imem[20] = r_type(7'h00, 12, 0, rv_isa_pkg::F3_ADD, 17);
        imem[21] = j_type(21'd0, 18);                          // Self-loop, relinks x18 each pass

        a = {{20{imm_a[11]}}, imm_a};
        b = {{20{imm_b[11]}}, imm_b};
        store_val = a + b;
        exp_rd = '{1, 2, 3, 6, 7, 8, 9, 10, 11, 4, 5, 12, 15, 17, 18, 0};
        exp_val[0] = a;
        exp_val[1] = b;
        exp_val[2] = a + b;
        exp_val[3] = (a + b) - a;
        exp_val[4] = exp_val[3] & exp_val[2];
        exp_val[5] = exp_val[4] | a;
        exp_val[6] = exp_val[5] ^ b;
        exp_val[7] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        exp_val[8] = 32'h1234_5000;
        exp_val[9] = a + b;
        exp_val[10] = (a + b) + (a + b);
        exp_val[11] = 32'd5;
        exp_val[12] = 32'd72;                                  // Link of the JAL at byte 68
        exp_val[13] = 32'd5;
        exp_val[14] = 32'd88;                                  // Link of the loop at byte 84
        exp_val[15] = '0;

        f0 = check_fails;
        wait (RESET_N);
        @(posedge CLK);
        @(negedge CLK);
        finish_test("reset_state", f0);
        f0 = check_fails;
        wait (exp_idx >= 9);
        @(negedge CLK);
        finish_test("alu_forwarding", f0);
        f0 = check_fails;
        wait (exp_idx >= 11);
        @(negedge CLK);
        if (store_count != 1) begin
            check_fails++;
            $display("expected exactly one store, saw %0d", store_count);
        end
        finish_test("store_load_use", f0);
        f0 = check_fails;
        wait (exp_idx >= 13);
        @(negedge CLK);
        finish_test("branches_jump", f0);
        f0 = check_fails;
        wait (exp_idx >= 14);
        repeat (4) @(negedge CLK);
        CLEAR = 1'b1;
        repeat (3) @(negedge CLK);
        CLEAR = 1'b0;
        repeat (2) @(negedge CLK);
        finish_test("x0_and_clear", f0);

        $display("summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        @(posedge RESET_N);
        repeat (WATCH_CYCLES) @(posedge CLK);
        $display("run timed out after %0d cycles", WATCH_CYCLES);
        $display("tests failed");
        $finish;
    end

endmodule

//--- compile.f
core_types_pkg.sv
rv_isa_pkg.sv
reg_file.sv
alu.sv
decode_control.sv
hazard_forward.sv
pipelined_core.sv
tb_clock_gen.sv
tb_pipelined_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_pipelined_core -f compile.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1
